// File: Makefile
# Verilator build and run for the SPI register file testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_spi_regs
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard src/*.sv src/*.svh tb/*.sv)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)

check: run
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+src
src/spi_regs_pkg.sv
src/reg_bus_if.sv
src/spi_target.sv
src/spi_cmd_decoder.sv
src/reg_slice.sv
src/read_collector.sv
src/spi_regs_top.sv
tb/tb_spi_regs.sv

// File: src/read_collector.sv
// ##########################################################
// read collector
// registered mux over the slice read ports, zero for
// addresses past the mapped registers
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_consts.svh"

module read_collector (
    input  logic          clk,
    input  logic          reset_i,
    input  logic [7:0]    slice_data_i [`SPI_REGS_NUM_SLICES],  // per slice read byte
    reg_bus_if.collector  bus,
    output logic [7:0]    rd_byte_o     // one clk after addr
);

    logic [`SPI_REGS_SLICE_BITS-1:0] slice_sel;
    logic                            in_range;

    assign slice_sel = bus.addr[`SPI_REGS_SLICE_BITS+`SPI_REGS_REG_BITS-1:
                                `SPI_REGS_REG_BITS];

    // 16 mapped bytes, rest read as zero
    assign in_range = (bus.addr <
        `SPI_REGS_ADDR_BITS'(`SPI_REGS_NUM_SLICES * `SPI_REGS_PER_SLICE));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_byte_o <= 8'h00;
        end else begin
            rd_byte_o <= in_range ? slice_data_i[slice_sel] : 8'h00;
        end
    end

endmodule

`default_nettype wire

// File: src/reg_bus_if.sv
// ##########################################################
// register operation bus
// one strobed op from the command decoder to the slices,
// address also read by the read collector
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_consts.svh"

interface reg_bus_if
    import spi_regs_pkg::*;
();

    logic                           op_stb;     // one clk pulse per op
    reg_op_e                        op;         // valid with op_stb
    logic [`SPI_REGS_ADDR_BITS-1:0] addr;       // held between strobes
    logic [7:0]                     wdata;      // valid with op_stb

    modport decoder (
        output op_stb,
        output op,
        output addr,
        output wdata
    );

    modport slice (
        input  op_stb,
        input  op,
        input  addr,
        input  wdata
    );

    modport collector (
        input  addr             // read select only
    );

endinterface

`default_nettype wire

// File: src/reg_slice.sv
// ##########################################################
// register slice
// a few byte registers with write, set bits and clear bits,
// combinational read port and register 0 to the pins
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_consts.svh"

module reg_slice
    import spi_regs_pkg::*;
#(
    parameter int SLICE_INDEX = 0       // set by the generate loop
) (
    input  logic       clk,
    input  logic       reset_i,
    reg_bus_if.slice   bus,
    output logic [7:0] rd_data_o,       // byte at register field of addr
    output logic [7:0] reg0_o           // register 0 for out pins
);

    logic [`SPI_REGS_PER_SLICE-1:0][7:0] regs;
    logic [`SPI_REGS_REG_BITS-1:0]       reg_sel;
    logic                                hit;    // addr falls in this slice

    assign reg_sel = bus.addr[`SPI_REGS_REG_BITS-1:0];

    // upper address bits must be zero so 16..63 hit nothing
    assign hit = (bus.addr[`SPI_REGS_ADDR_BITS-1:`SPI_REGS_REG_BITS] ==
                  (`SPI_REGS_ADDR_BITS - `SPI_REGS_REG_BITS)'(SLICE_INDEX));

    assign rd_data_o = regs[reg_sel];
    assign reg0_o    = regs[0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs <= '0;
        end else if (bus.op_stb && hit) begin
            unique case (bus.op)
                OP_WRITE: regs[reg_sel] <= bus.wdata;
                OP_SET:   regs[reg_sel] <= regs[reg_sel] | bus.wdata;
                OP_CLEAR: regs[reg_sel] <= regs[reg_sel] & ~bus.wdata;
                default:  regs[reg_sel] <= regs[reg_sel];   // read
            endcase
        end
    end

    // contents only move on a decoder strobe
    a_stable_without_stb: assert property (
        @(posedge clk) disable iff (reset_i)
        !bus.op_stb |=> $stable(regs)
    ) else $error("reg_slice %0d: register changed without op strobe", SLICE_INDEX);

endmodule

`default_nettype wire

// File: src/spi_cmd_decoder.sv
// ##########################################################
// SPI command decoder
// first byte of a select period is opcode plus address,
// later bytes run a burst of register ops at rising addresses
// also picks the byte handed back to the SPI target
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_consts.svh"

module spi_cmd_decoder
    import spi_regs_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  logic       select_i,        // synced chip select level
    input  logic       rx_stb_i,        // byte received
    input  logic [7:0] rx_byte_i,
    input  logic       tx_stb_i,        // tx byte just loaded
    input  logic [7:0] rd_byte_i,       // registered read data
    output logic [7:0] tx_byte_o,       // next byte for CIPO
    reg_bus_if.decoder bus
);

    dec_state_e                     state;
    reg_op_e                        cmd_op;     // opcode of current burst
    reg_op_e                        rx_op;      // opcode field of rx byte
    logic [`SPI_REGS_ADDR_BITS-1:0] rx_addr;    // address field of rx byte
    logic [`SPI_REGS_ADDR_BITS-1:0] burst_addr; // next address to use
    logic [7:0]                     last_rx;    // echo and write data
    logic                           burst_stb;  // advance the burst

    assign rx_op   = reg_op_e'(rx_byte_i[7:`SPI_REGS_ADDR_BITS]);
    assign rx_addr = rx_byte_i[`SPI_REGS_ADDR_BITS-1:0];

    // reads step on each tx load, the rest on each received byte
    assign burst_stb = (cmd_op == OP_READ) ? tx_stb_i : rx_stb_i;

    assign bus.op    = cmd_op;
    assign bus.wdata = last_rx;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= ST_IDLE;
            cmd_op     <= OP_WRITE;
            burst_addr <= '0;
            bus.addr   <= '0;
            bus.op_stb <= 1'b0;
        end else begin
            bus.op_stb <= 1'b0;                 // pulse
            if (!select_i) begin
                state <= ST_IDLE;               // deselect ends any burst
            end else begin
                unique case (state)
                    ST_IDLE: begin
                        state <= ST_CMD;
                    end
                    ST_CMD: begin
                        if (rx_stb_i) begin
                            cmd_op     <= rx_op;
                            burst_addr <= rx_addr;
                            state      <= ST_DATA;
                            if (rx_op == OP_READ) begin
                                // fetch first byte before first data load
                                bus.addr   <= rx_addr;
                                burst_addr <= rx_addr + 1'b1;
                                bus.op_stb <= 1'b1;
                            end
                        end
                    end
                    ST_DATA: begin
                        if (burst_stb) begin
                            bus.addr   <= burst_addr;
                            burst_addr <= burst_addr + 1'b1;   // wraps at 64
                            bus.op_stb <= 1'b1;
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // data byte, no reset needed
    always_ff @(posedge clk) begin
        if (rx_stb_i) begin
            last_rx <= rx_byte_i;
        end
    end

    always_comb begin
        if (state != ST_DATA) begin
            tx_byte_o = `SPI_REGS_ID;           // answer to command byte
        end else if (cmd_op == OP_READ) begin
            tx_byte_o = rd_byte_i;
        end else begin
            tx_byte_o = last_rx;                // echo
        end
    end

    // no op leaves the decoder outside a select period
    a_no_op_idle: assert property (
        @(posedge clk) disable iff (reset_i)
        (state == ST_IDLE) |-> !bus.op_stb
    ) else $error("spi_cmd_decoder: op strobe while idle");

endmodule

`default_nettype wire

// File: src/spi_regs_consts.svh
// ##########################################################
// SPI register file constants
// slice geometry, address field widths and the ID byte
// ##########################################################

`ifndef SPI_REGS_CONSTS_SVH
`define SPI_REGS_CONSTS_SVH

`define SPI_REGS_NUM_SLICES 4       // register slices in the file
`define SPI_REGS_PER_SLICE  4       // byte registers per slice

`define SPI_REGS_SLICE_BITS 2       // slice field of an address
`define SPI_REGS_REG_BITS   2       // register field, low bits

`define SPI_REGS_ADDR_BITS  6       // address bits in a command byte

`define SPI_REGS_ID         8'hA5   // sent back during every command byte

`endif

// File: src/spi_regs_pkg.sv
// ##########################################################
// SPI register file types
// opcode carried in the command byte and decoder FSM states
// ##########################################################

`default_nettype none

package spi_regs_pkg;

    // top two bits of a command byte
    typedef enum logic [1:0] {
        OP_WRITE = 2'b00,   // replace byte
        OP_READ  = 2'b01,   // return byte, no change
        OP_SET   = 2'b10,   // or in data bits
        OP_CLEAR = 2'b11    // clear data bits
    } reg_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,    // deselected
        ST_CMD  = 2'b01,    // waiting for command byte
        ST_DATA = 2'b10     // burst data bytes
    } dec_state_e;

endpackage

`default_nettype wire

// File: src/spi_regs_top.sv
// ##########################################################
// SPI register file top
// SPI target, command decoder, register slices and read
// collector, register 0 of each slice on out_o
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_consts.svh"

module spi_regs_top (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              spi_sck_i,
    input  logic                              spi_copi_i,
    input  logic                              spi_cs_i,     // active low
    output logic                              spi_cipo_o,
    output logic [`SPI_REGS_NUM_SLICES*8-1:0] out_o         // reg 0 of each slice
);

    logic       select;
    logic       rx_stb;
    logic [7:0] rx_byte;
    logic       tx_stb;
    logic [7:0] tx_byte;
    logic [7:0] rd_byte;

    logic [7:0] slice_rd   [`SPI_REGS_NUM_SLICES];
    logic [7:0] slice_reg0 [`SPI_REGS_NUM_SLICES];

    reg_bus_if bus ();

    spi_target u_spi_target (
        .clk               (clk),
        .reset_i           (reset_i),
        .spi_sck_i         (spi_sck_i),
        .spi_copi_i        (spi_copi_i),
        .spi_cs_i          (spi_cs_i),
        .transmit_byte_i   (tx_byte),
        .spi_cipo_o        (spi_cipo_o),
        .select_o          (select),
        .receive_strobe_o  (rx_stb),
        .receive_byte_o    (rx_byte),
        .transmit_strobe_o (tx_stb)
    );

    spi_cmd_decoder u_decoder (
        .clk       (clk),
        .reset_i   (reset_i),
        .select_i  (select),
        .rx_stb_i  (rx_stb),
        .rx_byte_i (rx_byte),
        .tx_stb_i  (tx_stb),
        .rd_byte_i (rd_byte),
        .tx_byte_o (tx_byte),
        .bus       (bus.decoder)
    );

    for (genvar i = 0; i < `SPI_REGS_NUM_SLICES; i++) begin : g_slice
        reg_slice #(
            .SLICE_INDEX (i)
        ) u_slice (
            .clk       (clk),
            .reset_i   (reset_i),
            .bus       (bus.slice),
            .rd_data_o (slice_rd[i]),
            .reg0_o    (slice_reg0[i])
        );

        assign out_o[i*8 +: 8] = slice_reg0[i];     // slice i on byte i
    end

    read_collector u_collector (
        .clk          (clk),
        .reset_i      (reset_i),
        .slice_data_i (slice_rd),
        .bus          (bus.collector),
        .rd_byte_o    (rd_byte)
    );

endmodule

`default_nettype wire

// File: src/spi_target.sv
// ##########################################################
// SPI mode 0 byte target
// synchronizes SCK/COPI/CS to clk, shifts bytes in and out
// MSB first, strobes on each received and loaded byte
// SCK must stay at or below a quarter of clk
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module spi_target (
    input  logic       clk,                 // system clock
    input  logic       reset_i,             // sync, active high
    input  logic       spi_sck_i,           // SPI clock pin
    input  logic       spi_copi_i,          // data from initiator
    input  logic       spi_cs_i,            // chip select, active low
    input  logic [7:0] transmit_byte_i,     // next byte to shift out
    output logic       spi_cipo_o,          // data to initiator
    output logic       select_o,            // synced select level
    output logic       receive_strobe_o,    // one clk, byte received
    output logic [7:0] receive_byte_o,      // last received byte
    output logic       transmit_strobe_o    // one clk, byte loaded
);

    logic [1:0] cs_sync;        // shifts right, bit 0 is used
    logic [1:0] copi_sync;
    logic [2:0] sck_sync;       // extra stage for edge detect

    logic       sck_rise;
    logic       sck_fall;
    logic       cs_act;         // synced and inverted CS
    logic       copi_bit;

    logic [7:0] shift_q;        // in and out shift register
    logic [2:0] bit_cnt;        // bit within byte
    logic       sck_high;       // last edge seen was a rise

    assign sck_rise = (sck_sync[1:0] == 2'b10);    // newer bit high, older low
    assign sck_fall = (sck_sync[1:0] == 2'b01);
    assign cs_act   = cs_sync[0];
    assign copi_bit = copi_sync[0];                 // same delay as sck edge

    assign select_o   = cs_act;
    assign spi_cipo_o = shift_q[7];                 // MSB first

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_sync           <= 2'b00;
            copi_sync         <= 2'b00;
            sck_sync          <= 3'b000;
            shift_q           <= 8'h00;
            bit_cnt           <= 3'd0;
            sck_high          <= 1'b0;
            receive_strobe_o  <= 1'b0;
            transmit_strobe_o <= 1'b0;
        end else begin
            sck_sync  <= {spi_sck_i, sck_sync[2:1]};
            copi_sync <= {spi_copi_i, copi_sync[1]};
            cs_sync   <= {~spi_cs_i, cs_sync[1]};   // CS pin is active low

            receive_strobe_o  <= 1'b0;              // pulses by default
            transmit_strobe_o <= 1'b0;

            if (!cs_act) begin
                // idle, keep first byte on CIPO for mode 0
                shift_q           <= transmit_byte_i;
                transmit_strobe_o <= 1'b1;
                bit_cnt           <= 3'd0;
                sck_high          <= 1'b0;
            end else if (!sck_high && sck_rise) begin
                sck_high <= 1'b1;
                shift_q  <= {shift_q[6:0], copi_bit};   // sample on rise
                if (bit_cnt == 3'd7) begin
                    receive_strobe_o <= 1'b1;
                end
            end else if (sck_high && sck_fall) begin
                sck_high <= 1'b0;
                bit_cnt  <= bit_cnt + 3'd1;             // wraps to 0 after bit 7
                if (bit_cnt == 3'd7) begin
                    shift_q           <= transmit_byte_i;   // next byte out
                    transmit_strobe_o <= 1'b1;
                end
            end
        end
    end

    // received byte, no reset needed
    always_ff @(posedge clk) begin
        if (cs_act && !sck_high && sck_rise && bit_cnt == 3'd7) begin
            receive_byte_o <= {shift_q[6:0], copi_bit};
        end
    end

    // rise and fall of SCK are separated by at least two clk
    a_strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset_i)
        !(receive_strobe_o && transmit_strobe_o)
    ) else $error("spi_target: receive and transmit strobe together");

endmodule

`default_nettype wire

// File: tb/tb_spi_regs.sv
// ##########################################################
// SPI register file testbench
// SPI mode 0 initiator, 16 byte reference model, checks on
// CIPO bytes and out_o after write, read, set and clear bursts
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "spi_regs_consts.svh"

module tb_spi_regs
    import spi_regs_pkg::*;
();

    localparam int CLK_HALF_NS   = 20;          // 40 ns clk
    localparam int SCK_HALF_CLKS = 5;           // sck at clk/10
    localparam int MAX_BYTES     = 20;          // command plus 19 data
    localparam int NUM_REGS      = `SPI_REGS_NUM_SLICES * `SPI_REGS_PER_SLICE;
    localparam int NUM_XFERS     = 18;          // transfers issued below
    localparam int XFER_NS       = (MAX_BYTES * 16 * SCK_HALF_CLKS + 40) * 2 * CLK_HALF_NS;
    localparam int WATCHDOG_NS   = NUM_XFERS * XFER_NS + 20000;

    logic                              clk;
    logic                              reset_i;
    logic                              spi_sck;
    logic                              spi_copi;
    logic                              spi_cs;     // active low
    logic                              spi_cipo;
    logic [`SPI_REGS_NUM_SLICES*8-1:0] out_w;

    logic [7:0] tx_buf [MAX_BYTES];             // bytes sent with the command in [0]
    logic [7:0] rx_buf [MAX_BYTES];             // bytes captured on CIPO
    logic [7:0] model  [NUM_REGS];              // expected register contents
    int         errors;
    int         checks;
    int         start_addr;
    int         burst_len;

    spi_regs_top u_spi_regs_top (
        .clk        (clk),
        .reset_i    (reset_i),
        .spi_sck_i  (spi_sck),
        .spi_copi_i (spi_copi),
        .spi_cs_i   (spi_cs),
        .spi_cipo_o (spi_cipo),
        .out_o      (out_w)
    );

    always #(CLK_HALF_NS) clk = ~clk;

    // inputs change just after the rising edge
    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // one select period with COPI set in the low half and CIPO sampled at the rise
    task automatic spi_transfer(input int nbytes);
        logic [7:0] rx;
        rx = 8'h00;
        spi_cs = 1'b0;
        wait_clks(SCK_HALF_CLKS);
        for (int b = 0; b < nbytes; b++) begin
            for (int i = 7; i >= 0; i--) begin
                spi_copi = tx_buf[b][i];            // MSB first
                wait_clks(SCK_HALF_CLKS);
                rx = {rx[6:0], spi_cipo};
                spi_sck = 1'b1;
                wait_clks(SCK_HALF_CLKS);
                spi_sck = 1'b0;
            end
            rx_buf[b] = rx;
        end
        wait_clks(SCK_HALF_CLKS);
        spi_cs = 1'b1;
        wait_clks(4 * SCK_HALF_CLKS);               // gap before next select
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at time %0t: %s got %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    function automatic logic [7:0] expected_read(input int a);
        if (a < NUM_REGS) begin
            return model[a];
        end
        return 8'h00;                               // unmapped reads as zero
    endfunction

    function automatic void update_model(input reg_op_e op, input int a, input logic [7:0] d);
        if (a < NUM_REGS) begin
            case (op)
                OP_WRITE: model[a] = d;
                OP_SET:   model[a] = model[a] | d;
                OP_CLEAR: model[a] = model[a] & ~d;
                default:  model[a] = model[a];
            endcase
        end
    endfunction

    task automatic fill_random(input int ndata);
        for (int k = 1; k <= ndata; k++) begin
            tx_buf[k] = 8'($urandom);
        end
    endtask

    // register 0 of slice i sits on byte i of out_o
    task automatic check_outputs();
        for (int i = 0; i < `SPI_REGS_NUM_SLICES; i++) begin
            check_byte(out_w[i*8 +: 8], model[i * `SPI_REGS_PER_SLICE],
                       $sformatf("out_o byte %0d", i));
        end
    endtask

    // command byte then ndata data bytes from tx_buf[1..]
    task automatic run_burst(input reg_op_e op, input int start, input int ndata);
        int a;
        tx_buf[0] = {op, 6'(start)};
        spi_transfer(ndata + 1);
        check_byte(rx_buf[0], `SPI_REGS_ID, "command byte response");
        for (int k = 1; k <= ndata; k++) begin
            a = (start + k - 1) % 64;               // burst address wraps at 64
            if (op == OP_READ) begin
                check_byte(rx_buf[k], expected_read(a), $sformatf("read of address %0d", a));
            end else begin
                if (k >= 2) begin
                    check_byte(rx_buf[k], tx_buf[k-1],
                               $sformatf("echo of data byte %0d", k - 1));
                end
                update_model(op, a, tx_buf[k]);
            end
        end
    endtask

    initial begin
        void'($urandom(46048));
        errors   = 0;
        checks   = 0;
        clk      = 1'b0;
        reset_i  = 1'b1;
        spi_sck  = 1'b0;
        spi_copi = 1'b0;
        spi_cs   = 1'b1;
        for (int r = 0; r < NUM_REGS; r++) begin
            model[r] = 8'h00;
        end
        for (int b = 0; b < MAX_BYTES; b++) begin
            tx_buf[b] = 8'h00;                      // COPI idles low on read bursts
        end
        wait_clks(2);
        reset_i = 1'b0;
        wait_clks(4);

        // state right after reset
        check_outputs();
        run_burst(OP_READ, 0, NUM_REGS);

        fill_random(NUM_REGS);                      // write every register
        run_burst(OP_WRITE, 0, NUM_REGS);
        check_outputs();

        repeat (4) begin
            start_addr = $urandom % NUM_REGS;
            burst_len  = 1 + $urandom % 6;
            fill_random(burst_len);
            run_burst(OP_WRITE, start_addr, burst_len);
            check_outputs();
        end

        // every read burst runs past address 15
        repeat (4) begin
            start_addr = $urandom % NUM_REGS;
            burst_len  = NUM_REGS + 3 - start_addr;
            run_burst(OP_READ, start_addr, burst_len);
        end

        for (int n = 0; n < 4; n++) begin
            start_addr = $urandom % NUM_REGS;
            burst_len  = 1 + $urandom % 5;
            fill_random(burst_len);
            if (n % 2 == 0) begin
                run_burst(OP_SET, start_addr, burst_len);
            end else begin
                run_burst(OP_CLEAR, start_addr, burst_len);
            end
            run_burst(OP_READ, 0, NUM_REGS);        // read back all
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, SPI transfers did not finish within %0d ns", WATCHDOG_NS);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
